//--- common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// one machine word, for data and instructions
`define ISA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define SHAMT_WIDTH 5

// both memories hold 64 words, indexed by word
`define IMEM_ADDR_WIDTH 6
`define DMEM_ADDR_WIDTH 6

`endif

//--- common/isa_pkg.sv
`default_nettype none
`include "cpu_defs.svh"

package isa_pkg;

    typedef logic [`ISA_WIDTH-1:0] word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL = 6'd0,
        F_ADD = 6'd32,
        F_SUB = 6'd34,
        F_AND = 6'd36,
        F_OR  = 6'd37,
        F_SLT = 6'd42
    } funct_e;

    // how an instruction moves through the pipe, CLS_NONE is a bubble
    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU_R,
        CLS_ALU_I,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP
    } instr_class_e;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_e;

    // where an EX operand comes from
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- hw/core/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module fetch_unit (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          program_load,
    input  wire                          imem_write_enable,
    input  wire [`IMEM_ADDR_WIDTH-1:0]   imem_write_addr,
    input  wire isa_pkg::word_t          imem_write_data,
    input  wire                          stall,
    input  wire                          flush,
    input  wire isa_pkg::word_t          branch_target,
    output logic                         id_valid,
    output isa_pkg::word_t               id_pc,
    output isa_pkg::word_t               id_instruction
);
    localparam int IMEM_DEPTH = 1 << `IMEM_ADDR_WIDTH;

    isa_pkg::word_t imem [IMEM_DEPTH];
    isa_pkg::word_t pc;
    logic [`IMEM_ADDR_WIDTH-1:0] pc_index;

    // pc is a byte address
    assign pc_index = pc[`IMEM_ADDR_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (program_load && imem_write_enable) begin
            imem[imem_write_addr] <= imem_write_data;
        end
    end

    // pc parks at 0 while a program is loaded
    always_ff @(posedge clk) begin
        if (reset || program_load) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= flush ? branch_target : pc + 4;
            id_valid <= !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc          <= pc;
            id_instruction <= imem[pc_index];
        end
    end

endmodule

`default_nettype wire

//--- hw/core/register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module register_file (
    input  wire                      clk,
    input  wire                      reset,
    input  wire isa_pkg::reg_idx_t   read_addr_1,
    input  wire isa_pkg::reg_idx_t   read_addr_2,
    input  wire                      write_enable,
    input  wire isa_pkg::reg_idx_t   write_addr,
    input  wire isa_pkg::word_t      write_data,
    output isa_pkg::word_t           read_data_1,
    output isa_pkg::word_t           read_data_2
);
    localparam int REG_COUNT = 1 << `REG_ADDR_WIDTH;

    isa_pkg::word_t regs [REG_COUNT];

    // r0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // a same-cycle write is seen by the read
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t addr);
        if (write_enable && addr != '0 && addr == write_addr) begin
            return write_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        read_data_1 = read_port(read_addr_1);
        read_data_2 = read_port(read_addr_2);
    end

endmodule

`default_nettype wire

//--- hw/core/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module decode_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      id_valid,
    input  wire isa_pkg::word_t      id_pc,
    input  wire isa_pkg::word_t      id_instruction,
    input  wire isa_pkg::word_t      read_data_1,
    input  wire isa_pkg::word_t      read_data_2,
    input  wire                      stall,
    output isa_pkg::reg_idx_t        read_addr_1,
    output isa_pkg::reg_idx_t        read_addr_2,
    output logic                     branch_taken,
    output isa_pkg::word_t           branch_target,
    output logic                     id_uses_rs,
    output logic                     id_uses_rt,
    output logic                     id_is_branch,
    output logic                     ex_valid,
    output pipe_pkg::alu_op_e        ex_alu_op,
    output isa_pkg::word_t           ex_operand_1,
    output isa_pkg::word_t           ex_operand_2,
    output isa_pkg::word_t           ex_store_data,
    output isa_pkg::reg_idx_t        ex_rs,
    output isa_pkg::reg_idx_t        ex_rt,
    output isa_pkg::reg_idx_t        ex_dest,
    output logic                     ex_reg_write,
    output logic                     ex_mem_read,
    output logic                     ex_mem_write
);
    isa_pkg::opcode_e        opcode;
    isa_pkg::funct_e         funct;
    isa_pkg::instr_class_e   cls;
    pipe_pkg::alu_op_e       alu_op;
    isa_pkg::reg_idx_t       rs;
    isa_pkg::reg_idx_t       rt;
    isa_pkg::reg_idx_t       rd;
    isa_pkg::reg_idx_t       dest;
    logic [`SHAMT_WIDTH-1:0] shamt;
    logic [15:0]             imm;
    logic [25:0]             jump_index;
    isa_pkg::word_t          imm_ext;
    isa_pkg::word_t          pc_plus4;
    logic                    is_shift;
    logic                    issue;

    assign opcode     = isa_pkg::opcode_e'(id_instruction[31:26]);
    assign rs         = id_instruction[25:21];
    assign rt         = id_instruction[20:16];
    assign rd         = id_instruction[15:11];
    assign shamt      = id_instruction[10:6];
    assign funct      = isa_pkg::funct_e'(id_instruction[5:0]);
    assign imm        = id_instruction[15:0];
    assign jump_index = id_instruction[25:0];

    assign read_addr_1 = rs;
    assign read_addr_2 = rt;

    always_comb begin
        cls    = isa_pkg::CLS_NONE;
        alu_op = pipe_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OP_RTYPE: begin
                cls = isa_pkg::CLS_ALU_R;
                case (funct)
                    isa_pkg::F_SLL: alu_op = pipe_pkg::ALU_SLL;
                    isa_pkg::F_ADD: alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::F_SUB: alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::F_AND: alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::F_OR:  alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::F_SLT: alu_op = pipe_pkg::ALU_SLT;
                    default:        cls = isa_pkg::CLS_NONE;
                endcase
            end
            isa_pkg::OP_ADDI: cls = isa_pkg::CLS_ALU_I;
            isa_pkg::OP_ANDI: begin
                cls    = isa_pkg::CLS_ALU_I;
                alu_op = pipe_pkg::ALU_AND;
            end
            isa_pkg::OP_ORI: begin
                cls    = isa_pkg::CLS_ALU_I;
                alu_op = pipe_pkg::ALU_OR;
            end
            isa_pkg::OP_LW:  cls = isa_pkg::CLS_LOAD;
            isa_pkg::OP_SW:  cls = isa_pkg::CLS_STORE;
            isa_pkg::OP_BEQ: cls = isa_pkg::CLS_BRANCH;
            isa_pkg::OP_BNE: cls = isa_pkg::CLS_BRANCH;
            isa_pkg::OP_J:   cls = isa_pkg::CLS_JUMP;
            default:         cls = isa_pkg::CLS_NONE;
        endcase
    end

    assign is_shift     = (cls == isa_pkg::CLS_ALU_R) && (funct == isa_pkg::F_SLL);
    assign id_is_branch = (cls == isa_pkg::CLS_BRANCH);
    assign id_uses_rs   = !is_shift && (cls != isa_pkg::CLS_NONE) && (cls != isa_pkg::CLS_JUMP);
    assign id_uses_rt   = cls inside {isa_pkg::CLS_ALU_R, isa_pkg::CLS_STORE,
                                      isa_pkg::CLS_BRANCH};
    assign dest         = (cls == isa_pkg::CLS_ALU_R) ? rd : rt;

    // logic immediates are zero extended
    assign imm_ext = (opcode == isa_pkg::OP_ANDI || opcode == isa_pkg::OP_ORI) ?
                     {16'b0, imm} : {{16{imm[15]}}, imm};

    assign pc_plus4      = id_pc + 4;
    assign branch_target = (cls == isa_pkg::CLS_JUMP) ?
                           {pc_plus4[31:28], jump_index, 2'b00} :
                           pc_plus4 + {imm_ext[29:0], 2'b00};
    assign branch_taken  = id_valid && ((cls == isa_pkg::CLS_JUMP) ||
                           (opcode == isa_pkg::OP_BEQ && read_data_1 == read_data_2) ||
                           (opcode == isa_pkg::OP_BNE && read_data_1 != read_data_2));

    assign issue = id_valid && !stall && (cls != isa_pkg::CLS_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_valid     <= issue;
            ex_reg_write <= issue && (dest != '0) &&
                            (cls inside {isa_pkg::CLS_ALU_R, isa_pkg::CLS_ALU_I,
                                         isa_pkg::CLS_LOAD});
            ex_mem_read  <= issue && (cls == isa_pkg::CLS_LOAD);
            ex_mem_write <= issue && (cls == isa_pkg::CLS_STORE);
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op     <= alu_op;
        ex_operand_1  <= is_shift ? isa_pkg::word_t'(shamt) : read_data_1;
        ex_operand_2  <= (cls == isa_pkg::CLS_ALU_R) ? read_data_2 : imm_ext;
        ex_store_data <= read_data_2;
        // r0 here means nothing to forward
        ex_rs         <= id_uses_rs ? rs : '0;
        ex_rt         <= id_uses_rt ? rt : '0;
        ex_dest       <= dest;
    end

endmodule

`default_nettype wire

//--- hw/core/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire                      id_valid,
    input  wire isa_pkg::reg_idx_t   id_rs,
    input  wire isa_pkg::reg_idx_t   id_rt,
    input  wire                      id_uses_rs,
    input  wire                      id_uses_rt,
    input  wire                      id_is_branch,
    input  wire                      branch_taken,
    input  wire                      ex_valid,
    input  wire                      ex_mem_read,
    input  wire                      ex_reg_write,
    input  wire isa_pkg::reg_idx_t   ex_dest,
    input  wire                      mem_valid,
    input  wire                      mem_mem_read,
    input  wire                      mem_reg_write,
    input  wire isa_pkg::reg_idx_t   mem_dest,
    output logic                     stall,
    output logic                     flush
);
    logic ex_hit;
    logic mem_hit;
    logic load_use;
    logic branch_wait;

    assign ex_hit  = ex_valid && ex_reg_write &&
                     ((id_uses_rs && ex_dest == id_rs) || (id_uses_rt && ex_dest == id_rt));
    assign mem_hit = mem_valid && (mem_reg_write || mem_mem_read) && (mem_dest != '0) &&
                     ((id_uses_rs && mem_dest == id_rs) || (id_uses_rt && mem_dest == id_rt));

    // ALU users get the load from WB one cycle later
    assign load_use = id_valid && ex_hit && ex_mem_read;

    // branches compare in ID, so wait until the source is in WB
    assign branch_wait = id_valid && id_is_branch && (ex_hit || mem_hit);

    assign stall = load_use || branch_wait;
    assign flush = branch_taken && !stall;

endmodule

`default_nettype wire

//--- hw/core/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module execute_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ex_valid,
    input  wire pipe_pkg::alu_op_e   ex_alu_op,
    input  wire isa_pkg::word_t      ex_operand_1,
    input  wire isa_pkg::word_t      ex_operand_2,
    input  wire isa_pkg::word_t      ex_store_data,
    input  wire isa_pkg::reg_idx_t   ex_rs,
    input  wire isa_pkg::reg_idx_t   ex_rt,
    input  wire isa_pkg::reg_idx_t   ex_dest,
    input  wire                      ex_reg_write,
    input  wire                      ex_mem_read,
    input  wire                      ex_mem_write,
    input  wire                      wb_valid,
    input  wire isa_pkg::reg_idx_t   wb_reg_idx,
    input  wire isa_pkg::word_t      wb_data,
    output logic                     mem_valid,
    output logic                     mem_reg_write,
    output logic                     mem_mem_read,
    output logic                     mem_mem_write,
    output isa_pkg::reg_idx_t        mem_dest,
    output isa_pkg::word_t           mem_result,
    output isa_pkg::word_t           mem_store_data
);
    pipe_pkg::fwd_sel_e sel_1;
    pipe_pkg::fwd_sel_e sel_2;
    pipe_pkg::fwd_sel_e sel_store;
    isa_pkg::word_t     a;
    isa_pkg::word_t     b;
    isa_pkg::word_t     store_value;
    isa_pkg::word_t     alu_result;

    // MEM wins over WB, a load in MEM never gets here
    function automatic pipe_pkg::fwd_sel_e fwd_select(input isa_pkg::reg_idx_t src);
        if (src == '0) begin
            return pipe_pkg::FWD_NONE;
        end
        if (mem_valid && mem_reg_write && mem_dest == src) begin
            return pipe_pkg::FWD_MEM;
        end
        if (wb_valid && wb_reg_idx == src) begin
            return pipe_pkg::FWD_WB;
        end
        return pipe_pkg::FWD_NONE;
    endfunction

    function automatic isa_pkg::word_t forward(input pipe_pkg::fwd_sel_e sel,
                                               input isa_pkg::word_t value);
        case (sel)
            pipe_pkg::FWD_MEM: return mem_result;
            pipe_pkg::FWD_WB:  return wb_data;
            default:           return value;
        endcase
    endfunction

    always_comb begin
        sel_1     = fwd_select(ex_rs);
        sel_store = fwd_select(ex_rt);
        // a store has its offset on operand 2, rt only feeds the store data
        sel_2     = ex_mem_write ? pipe_pkg::FWD_NONE : sel_store;

        a           = forward(sel_1, ex_operand_1);
        b           = forward(sel_2, ex_operand_2);
        store_value = forward(sel_store, ex_store_data);
    end

    always_comb begin
        case (ex_alu_op)
            pipe_pkg::ALU_SUB: alu_result = a - b;
            pipe_pkg::ALU_AND: alu_result = a & b;
            pipe_pkg::ALU_OR:  alu_result = a | b;
            pipe_pkg::ALU_SLT: alu_result = isa_pkg::word_t'($signed(a) < $signed(b));
            pipe_pkg::ALU_SLL: alu_result = b << a[`SHAMT_WIDTH-1:0];
            default:           alu_result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_valid && ex_reg_write;
            mem_mem_read  <= ex_valid && ex_mem_read;
            mem_mem_write <= ex_valid && ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_dest       <= ex_dest;
        mem_result     <= alu_result;
        mem_store_data <= store_value;
    end

endmodule

`default_nettype wire

//--- hw/core/memory_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module memory_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      mem_valid,
    input  wire                      mem_reg_write,
    input  wire                      mem_mem_read,
    input  wire                      mem_mem_write,
    input  wire isa_pkg::reg_idx_t   mem_dest,
    input  wire isa_pkg::word_t      mem_result,
    input  wire isa_pkg::word_t      mem_store_data,
    output logic                     wb_valid,
    output isa_pkg::reg_idx_t        wb_reg_idx,
    output isa_pkg::word_t           wb_data
);
    localparam int DMEM_DEPTH = 1 << `DMEM_ADDR_WIDTH;

    isa_pkg::word_t dmem [DMEM_DEPTH];
    logic [`DMEM_ADDR_WIDTH-1:0] word_addr;
    isa_pkg::word_t load_data;

    assign word_addr = mem_result[`DMEM_ADDR_WIDTH+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_mem_write) begin
            dmem[word_addr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid && mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg_idx <= mem_dest;
        wb_data    <= mem_mem_read ? load_data : mem_result;
    end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_top (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          program_load,
    input  wire                          imem_write_enable,
    input  wire [`IMEM_ADDR_WIDTH-1:0]   imem_write_addr,
    input  wire isa_pkg::word_t          imem_write_data,
    output logic                         wb_valid,
    output isa_pkg::reg_idx_t            wb_reg_idx,
    output isa_pkg::word_t               wb_data
);
    // hazard control
    logic stall;
    logic flush;

    // IF/ID
    logic           id_valid;
    isa_pkg::word_t id_pc;
    isa_pkg::word_t id_instruction;

    // ID side
    isa_pkg::reg_idx_t read_addr_1;
    isa_pkg::reg_idx_t read_addr_2;
    isa_pkg::word_t    read_data_1;
    isa_pkg::word_t    read_data_2;
    logic              branch_taken;
    isa_pkg::word_t    branch_target;
    logic              id_uses_rs;
    logic              id_uses_rt;
    logic              id_is_branch;

    // ID/EX
    logic              ex_valid;
    pipe_pkg::alu_op_e ex_alu_op;
    isa_pkg::word_t    ex_operand_1;
    isa_pkg::word_t    ex_operand_2;
    isa_pkg::word_t    ex_store_data;
    isa_pkg::reg_idx_t ex_rs;
    isa_pkg::reg_idx_t ex_rt;
    isa_pkg::reg_idx_t ex_dest;
    logic              ex_reg_write;
    logic              ex_mem_read;
    logic              ex_mem_write;

    // EX/MEM
    logic              mem_valid;
    logic              mem_reg_write;
    logic              mem_mem_read;
    logic              mem_mem_write;
    isa_pkg::reg_idx_t mem_dest;
    isa_pkg::word_t    mem_result;
    isa_pkg::word_t    mem_store_data;

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    register_file u_regs (
        .write_enable (wb_valid),
        .write_addr   (wb_reg_idx),
        .write_data   (wb_data),
        .*
    );

    hazard_unit u_hazard (
        .id_rs (read_addr_1),
        .id_rt (read_addr_2),
        .*
    );

    execute_unit u_execute (.*);

    memory_unit u_memory (.*);

endmodule

`default_nettype wire

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;
    localparam int CLK_PERIOD = 4;
    localparam int IMEM_DEPTH = 1 << `IMEM_ADDR_WIDTH;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        program_load;
    logic                        imem_write_enable;
    logic [`IMEM_ADDR_WIDTH-1:0] imem_write_addr;
    isa_pkg::word_t              imem_write_data;
    logic                        wb_valid;
    isa_pkg::reg_idx_t           wb_reg_idx;
    isa_pkg::word_t              wb_data;

    // one row per instruction word at consecutive word addresses
    string             test_name[$];
    isa_pkg::word_t    program_word[$];
    isa_pkg::reg_idx_t expect_reg[$];
    isa_pkg::word_t    expect_value[$];
    // rows that show up on the write-back trace in program order
    int                wb_rows[$];

    int errors;
    int wb_seen;
    bit checking;
    bit table_ready;

    cpu_top u_dut (
        .clk               (clk),
        .reset             (reset),
        .program_load      (program_load),
        .imem_write_enable (imem_write_enable),
        .imem_write_addr   (imem_write_addr),
        .imem_write_data   (imem_write_data),
        .wb_valid          (wb_valid),
        .wb_reg_idx        (wb_reg_idx),
        .wb_data           (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic isa_pkg::word_t rtype_word(input isa_pkg::funct_e funct,
                                                  input isa_pkg::reg_idx_t rd,
                                                  input isa_pkg::reg_idx_t rs,
                                                  input isa_pkg::reg_idx_t rt,
                                                  input logic [`SHAMT_WIDTH-1:0] shamt);
        return {isa_pkg::OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    // rt is the destination for ALU immediates and loads
    function automatic isa_pkg::word_t itype_word(input isa_pkg::opcode_e op,
                                                  input isa_pkg::reg_idx_t rs,
                                                  input isa_pkg::reg_idx_t rt,
                                                  input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isa_pkg::word_t jump_word(input int word_index);
        return {isa_pkg::OP_J, 26'(word_index)};
    endfunction

    function automatic void add_row(input string name, input isa_pkg::word_t word,
                                    input bit has_wb, input isa_pkg::reg_idx_t rd,
                                    input isa_pkg::word_t value);
        if (has_wb) begin
            wb_rows.push_back(test_name.size());
        end
        test_name.push_back(name);
        program_word.push_back(word);
        expect_reg.push_back(rd);
        expect_value.push_back(value);
    endfunction

    function automatic void build_table();
        add_row("addi_pos", itype_word(isa_pkg::OP_ADDI, 0, 1, 16'd5), 1, 1, 32'h0000_0005);
        add_row("addi_neg", itype_word(isa_pkg::OP_ADDI, 0, 2, 16'hFFFD), 1, 2, 32'hFFFF_FFFD);
        // 5 + -3
        add_row("add_fwd", rtype_word(isa_pkg::F_ADD, 3, 1, 2, 0), 1, 3, 32'h0000_0002);
        add_row("sub_fwd", rtype_word(isa_pkg::F_SUB, 4, 3, 1, 0), 1, 4, 32'hFFFF_FFFD);
        add_row("and_fwd", rtype_word(isa_pkg::F_AND, 5, 4, 1, 0), 1, 5, 32'h0000_0005);
        add_row("or_fwd", rtype_word(isa_pkg::F_OR, 6, 5, 2, 0), 1, 6, 32'hFFFF_FFFD);
        // -3 < 5 signed
        add_row("slt_signed", rtype_word(isa_pkg::F_SLT, 7, 6, 5, 0), 1, 7, 32'h0000_0001);
        add_row("andi_zext", itype_word(isa_pkg::OP_ANDI, 2, 8, 16'hFFF0), 1, 8, 32'h0000_FFF0);
        add_row("ori_zext", itype_word(isa_pkg::OP_ORI, 0, 9, 16'h8001), 1, 9, 32'h0000_8001);
        add_row("sll_shift", rtype_word(isa_pkg::F_SLL, 10, 0, 9, 4), 1, 10, 32'h0008_0010);
        add_row("sw_store", itype_word(isa_pkg::OP_SW, 0, 10, 16'd8), 0, 0, 32'h0);
        add_row("lw_load", itype_word(isa_pkg::OP_LW, 0, 11, 16'd8), 1, 11, 32'h0008_0010);
        add_row("load_use_add", rtype_word(isa_pkg::F_ADD, 12, 11, 1, 0), 1, 12, 32'h0008_0015);
        // target is two words past the next one
        add_row("beq_taken", itype_word(isa_pkg::OP_BEQ, 1, 1, 16'd2), 0, 0, 32'h0);
        add_row("beq_skip_1", itype_word(isa_pkg::OP_ADDI, 0, 13, 16'd99), 0, 0, 32'h0);
        add_row("beq_skip_2", itype_word(isa_pkg::OP_ADDI, 0, 13, 16'd98), 0, 0, 32'h0);
        add_row("bne_not_taken", itype_word(isa_pkg::OP_BNE, 1, 1, 16'd1), 0, 0, 32'h0);
        add_row("after_bne", itype_word(isa_pkg::OP_ADDI, 0, 14, 16'd7), 1, 14, 32'h0000_0007);
        add_row("bne_dep", itype_word(isa_pkg::OP_BNE, 14, 0, 16'd1), 0, 0, 32'h0);
        add_row("bne_skip", itype_word(isa_pkg::OP_ADDI, 0, 15, 16'd1), 0, 0, 32'h0);
        add_row("addi_r0", itype_word(isa_pkg::OP_ADDI, 0, 0, 16'd55), 0, 0, 32'h0);
        add_row("add_from_r0", rtype_word(isa_pkg::F_ADD, 16, 0, 1, 0), 1, 16, 32'h0000_0005);
        add_row("j_forward", jump_word(24), 0, 0, 32'h0);
        add_row("j_skip", itype_word(isa_pkg::OP_ADDI, 0, 17, 16'd1), 0, 0, 32'h0);
        add_row("j_self", jump_word(24), 0, 0, 32'h0);
    endfunction

    task automatic load_program();
        int addr;
        program_load = 1'b1;
        for (addr = 0; addr < IMEM_DEPTH; addr++) begin
            imem_write_enable = 1'b1;
            imem_write_addr   = addr[`IMEM_ADDR_WIDTH-1:0];
            // words past the program jump to themselves
            imem_write_data   = (addr < program_word.size()) ? program_word[addr] :
                                jump_word(addr);
            @(posedge clk);
            #1;
        end
        imem_write_enable = 1'b0;
        program_load      = 1'b0;
    endtask

    function automatic void check_writeback();
        int row;
        if (wb_reg_idx === '0) begin
            $display("A write-back to r0 appeared on the trace");
            errors++;
        end
        if (wb_seen >= wb_rows.size()) begin
            $display("Unexpected write-back to r%0d (%h) after the last expected one",
                     wb_reg_idx, wb_data);
            errors++;
        end else begin
            row = wb_rows[wb_seen];
            wb_seen++;
            if (wb_reg_idx !== expect_reg[row] || wb_data !== expect_value[row]) begin
                $display("Mismatch %s: expected r%0d = %h, actual r%0d = %h", test_name[row],
                         expect_reg[row], expect_value[row], wb_reg_idx, wb_data);
                errors++;
            end
        end
    endfunction

    // outputs are stable by the falling edge
    always @(negedge clk) begin
        if ((reset || program_load) && wb_valid !== 1'b0) begin
            $display("wb_valid was not low during reset or program load at %0t", $time);
            errors++;
        end
        if (checking && wb_valid === 1'b1) begin
            check_writeback();
        end
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = (test_name.size() * 20 + 100) * CLK_PERIOD;
        #(limit);
        $display("Watchdog timeout: the run did not finish within %0d ns", limit);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int window;
        reset             = 1'b1;
        program_load      = 1'b0;
        imem_write_enable = 1'b0;
        imem_write_addr   = '0;
        imem_write_data   = '0;
        errors            = 0;
        wb_seen           = 0;
        checking          = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        load_program();
        checking = 1'b1;

        window = test_name.size() * 10;
        while (wb_seen < wb_rows.size() && window > 0) begin
            @(posedge clk);
            window--;
        end
        // stray write-backs would show up in this stretch
        repeat (20) @(posedge clk);
        if (wb_seen < wb_rows.size()) begin
            $display("Missing write-backs: saw %0d of %0d", wb_seen, wb_rows.size());
            errors++;
        end

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hw/core/fetch_unit.sv
hw/core/register_file.sv
hw/core/decode_unit.sv
hw/core/hazard_unit.sv
hw/core/execute_unit.sv
hw/core/memory_unit.sv
hw/cpu_top.sv
sim/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = cpu_tb
FILE_LIST = tb.f
PASS_MSG  = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
